// ==== rtl/music_settings.svh ====
`ifndef MUSIC_SETTINGS_SVH
`define MUSIC_SETTINGS_SVH

// Note number width, note 0 is a rest
`define MUSIC_NOTE_W    6
`define MUSIC_DUR_W     6     // Duration in beats
`define MUSIC_STEP_W    20    // Phase step per sample
`define MUSIC_PHASE_W   22    // Phase accumulator width
`define MUSIC_SONG_AW   5     // 32 song entries
`define MUSIC_BEAT_DIV  16    // Clocks per beat, kept small for simulation

`define MUSIC_SAMPLE_W  16    // Signed audio sample width
`define MUSIC_SINE_AW   6     // Quarter-wave table address width

`endif

// ==== rtl/music_pkg.sv ====
`include "music_settings.svh"

package music_pkg;

    // Signed audio sample as sent to the codec
    typedef logic signed [`MUSIC_SAMPLE_W-1:0] sample_t;

    typedef logic [`MUSIC_PHASE_W-1:0] phase_t;  // Accumulated phase, MSBs select the sine

    // Top bits of the phase that drive the sine table
    typedef struct packed {
        logic [1:0]                quadrant;  // Which quarter of the period
        logic [`MUSIC_SINE_AW-1:0] addr;      // Index into the quarter-wave table
    } sine_sel_t;

    // One song entry, also the load payload to the note player
    typedef struct packed {
        logic [`MUSIC_NOTE_W-1:0] note;      // Semitone number, 0 is a rest
        logic [`MUSIC_DUR_W-1:0]  duration;  // Length in beats, 0 ends the song
    } note_cmd_t;

endpackage

// ==== rtl/song_rom.sv ====
`timescale 1ns/1ps
`include "music_settings.svh"

module song_rom (
    input  logic                      clk,
    input  logic [`MUSIC_SONG_AW-1:0] song_addr,  // Entry to read
    output music_pkg::note_cmd_t      note_cmd    // Entry contents, one cycle later
);

    music_pkg::note_cmd_t rom_word;  // Combinational table output

    always_comb begin
        case (song_addr)
            // Short phrase, durations kept small for quick runs
            5'd0:    rom_word = '{6'd25, 6'd2};
            5'd1:    rom_word = '{6'd27, 6'd2};
            5'd2:    rom_word = '{6'd29, 6'd1};
            5'd3:    rom_word = '{6'd30, 6'd3};
            5'd4:    rom_word = '{6'd0,  6'd2};  // Rest
            5'd5:    rom_word = '{6'd32, 6'd2};
            5'd6:    rom_word = '{6'd34, 6'd1};
            5'd7:    rom_word = '{6'd37, 6'd4};
            5'd8:    rom_word = '{6'd36, 6'd2};
            5'd9:    rom_word = '{6'd0,  6'd1};  // Rest
            5'd10:   rom_word = '{6'd49, 6'd2};  // Octave jump
            5'd11:   rom_word = '{6'd44, 6'd3};
            default: rom_word = '{6'd0,  6'd0};  // Zero duration marks end of song
        endcase
    end

    // Registered read port
    always_ff @(posedge clk) begin
        note_cmd <= rom_word;
    end

endmodule

// ==== rtl/frequency_rom.sv ====
`timescale 1ns/1ps
`include "music_settings.svh"

module frequency_rom (
    input  logic                     clk,
    input  logic [`MUSIC_NOTE_W-1:0] note,       // Semitone number, 0 is a rest
    output logic [`MUSIC_STEP_W-1:0] step_size   // Phase increment, one cycle later
);

    // Lowest octave steps, equal temperament, about 65.4 Hz at 48 kHz sampling
    localparam logic [`MUSIC_STEP_W-1:0] BASE_STEP [12] = '{
        5715,   // C
        6055,   // C#
        6415,   // D
        6796,   // D#
        7200,   // E
        7629,   // F
        8082,   // F#
        8563,   // G
        9072,   // G#
        9611,   // A
        10183,  // A#
        10789   // B
    };

    logic [2:0]               octave;     // Up to 5 for 6-bit notes
    logic [3:0]               semitone;   // 0 to 11
    logic [`MUSIC_STEP_W-1:0] base_step;  // Step within the lowest octave

    always_comb begin
        octave    = 3'(note / 12);
        semitone  = 4'(note % 12);
        base_step = BASE_STEP[semitone];  // Semitone never exceeds 11
    end

    // Each octave doubles the frequency
    always_ff @(posedge clk) begin
        if (note == '0) begin
            step_size <= '0;  // Rest, zero step silences the readers
        end else begin
            step_size <= base_step << octave;
        end
    end

endmodule

// ==== rtl/sine_rom.sv ====
`timescale 1ns/1ps
`include "music_settings.svh"

module sine_rom (
    input  logic                  clk,
    input  music_pkg::sine_sel_t  phase_sel,  // Quadrant and table index
    output music_pkg::sample_t    sample      // Full-wave sample, one cycle later
);

    // First quarter of sin, scaled to 32767, entry 0 is exactly zero
    localparam music_pkg::sample_t QUARTER_WAVE [1 << `MUSIC_SINE_AW] = '{
        0,     804,   1608,  2410,  3212,  4011,  4808,  5602,
        6393,  7179,  7962,  8739,  9512,  10278, 11039, 11793,
        12539, 13279, 14010, 14732, 15446, 16151, 16846, 17530,
        18204, 18868, 19519, 20159, 20787, 21403, 22005, 22594,
        23170, 23731, 24279, 24811, 25329, 25832, 26319, 26790,
        27245, 27683, 28105, 28510, 28898, 29268, 29621, 29956,
        30273, 30571, 30852, 31113, 31356, 31580, 31785, 31971,
        32137, 32285, 32412, 32521, 32609, 32678, 32728, 32757
    };

    logic [`MUSIC_SINE_AW-1:0] table_addr;  // Index after mirroring
    music_pkg::sample_t        magnitude;   // Unsigned-shaped table value

    always_comb begin
        // Quadrants 1 and 3 run the table backwards
        if (phase_sel.quadrant[0]) begin
            table_addr = ~phase_sel.addr;
        end else begin
            table_addr = phase_sel.addr;
        end
        magnitude = QUARTER_WAVE[table_addr];
    end

    // Second half of the period is the negative lobe
    always_ff @(posedge clk) begin
        if (phase_sel.quadrant[1]) begin
            sample <= -magnitude;
        end else begin
            sample <= magnitude;
        end
    end

endmodule

// ==== rtl/sine_reader.sv ====
`timescale 1ns/1ps
`include "music_settings.svh"

module sine_reader (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`MUSIC_STEP_W-1:0] step_size,      // Phase increment per sample
    input  logic                     generate_next,  // One-cycle sample request
    output music_pkg::sample_t       sample          // Valid two cycles after the request
);

    music_pkg::phase_t    phase;      // Running phase accumulator
    music_pkg::phase_t    step_ext;   // Step widened to phase width
    music_pkg::sine_sel_t phase_sel;  // Top phase bits to the table

    // Zero-extend, the step is always a positive increment
    assign step_ext = music_pkg::phase_t'(step_size);

    // Stage one of the sample pipeline
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
        end else if (step_size == '0) begin
            phase <= '0;  // Rest parks at table entry 0, so output is exactly 0
        end else if (generate_next) begin
            phase <= phase + step_ext;  // Wraps naturally at full period
        end
    end

    // Quadrant and table index come straight off the MSBs
    assign phase_sel = phase[`MUSIC_PHASE_W-1 -: $bits(music_pkg::sine_sel_t)];

    // Stage two, registered table read
    sine_rom sine_table (
        .clk      (clk),
        .phase_sel(phase_sel),
        .sample   (sample)
    );

endmodule

// ==== rtl/note_player.sv ====
`timescale 1ns/1ps
`include "music_settings.svh"

module note_player (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 play_enable,           // Level, pauses playback when low
    input  logic                 load_new_note,         // One-cycle load strobe
    input  music_pkg::note_cmd_t note_cmd,              // Note and duration to load
    input  logic                 beat,                  // One-cycle beat tick
    input  logic                 generate_next_sample,  // Codec sample request
    output logic                 done_with_note,        // Stays high once the note has run out
    output music_pkg::sample_t   sample_out,            // Mixed sample, holds between pulses
    output logic                 new_sample_ready       // Pulse three cycles after a request
);

    logic [`MUSIC_NOTE_W-1:0] note;             // Note currently sounding
    logic [`MUSIC_DUR_W-1:0]  beats_left;       // Duration countdown
    logic [`MUSIC_STEP_W-1:0] step_size;        // Fundamental step
    logic [`MUSIC_STEP_W-1:0] overtone_step;    // Twice the fundamental
    logic                     generate_next;    // Request qualified by play_enable
    logic [2:0]               strobe_pipe;      // Tracks requests through the pipeline
    music_pkg::sample_t       fund_sample;
    music_pkg::sample_t       overtone_sample;
    logic [`MUSIC_SAMPLE_W:0] mix_sum;          // One extra bit for overflow

    // Note register, feeds the step lookup
    always_ff @(posedge clk) begin
        if (reset) begin
            note <= '0;  // Start on a rest
        end else if (load_new_note) begin
            note <= note_cmd.note;
        end
    end

    // Counts beats down to zero, then holds there
    always_ff @(posedge clk) begin
        if (reset) begin
            beats_left <= '0;
        end else if (play_enable && load_new_note) begin
            beats_left <= note_cmd.duration;
        end else if (play_enable && beat && !done_with_note) begin
            beats_left <= beats_left - 1'b1;
        end
    end
    assign done_with_note = (beats_left == '0);

    frequency_rom freq_rom (.clk(clk), .note(note), .step_size(step_size));

    assign generate_next = play_enable && generate_next_sample;
    assign overtone_step = step_size << 1;  // One octave up

    sine_reader fund_reader (
        .clk(clk), .reset(reset), .step_size(step_size),
        .generate_next(generate_next), .sample(fund_sample)
    );
    sine_reader overtone_reader (
        .clk(clk), .reset(reset), .step_size(overtone_step),
        .generate_next(generate_next), .sample(overtone_sample)
    );

    // Fundamental plus overtone at half amplitude, sign-extended to 17 bits
    assign mix_sum = {fund_sample[`MUSIC_SAMPLE_W-1], fund_sample}
                   + {{2{overtone_sample[`MUSIC_SAMPLE_W-1]}},
                      overtone_sample[`MUSIC_SAMPLE_W-1:1]};

    // Stage three, mix register and strobe delay
    always_ff @(posedge clk) begin
        if (reset) begin
            strobe_pipe <= '0;
            sample_out  <= '0;
        end else begin
            strobe_pipe <= {strobe_pipe[1:0], generate_next};
            if (strobe_pipe[1]) begin
                // Sign bits disagree on overflow, so fold by halving the sum
                if (mix_sum[`MUSIC_SAMPLE_W] != mix_sum[`MUSIC_SAMPLE_W-1]) begin
                    sample_out <= mix_sum[`MUSIC_SAMPLE_W:1];
                end else begin
                    sample_out <= mix_sum[`MUSIC_SAMPLE_W-1:0];
                end
            end
        end
    end
    assign new_sample_ready = strobe_pipe[2];

endmodule

// ==== rtl/song_sequencer.sv ====
`timescale 1ns/1ps
`include "music_settings.svh"

module song_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      play_enable,     // Level, freezes the song when low
    input  music_pkg::note_cmd_t      note_cmd,        // Song ROM output
    input  logic                      done_with_note,  // Level from the note player
    output logic [`MUSIC_SONG_AW-1:0] song_addr,       // Next entry to play
    output logic                      load_new_note,   // One-cycle load strobe
    output music_pkg::note_cmd_t      load_cmd,        // Payload for the load
    output logic                      beat,            // Pulse every MUSIC_BEAT_DIV cycles
    output logic [`MUSIC_SONG_AW-1:0] note_index,      // Entry now sounding
    output logic                      song_done        // Set once the end entry is read
);

    localparam int BEAT_CW = $clog2(`MUSIC_BEAT_DIV);

    typedef enum logic [1:0] {
        S_WAIT,   // Note playing, wait for it to finish
        S_FETCH,  // Address on the ROM, read in progress
        S_READY,  // ROM word valid, load or stop
        S_END     // Song finished, stays here until reset
    } state_t;

    state_t             state, next_state;
    logic [BEAT_CW-1:0] beat_count;
    logic               end_of_song;  // Zero duration entry

    // Beat divider, only runs while playing
    always_ff @(posedge clk) begin
        if (reset) begin
            beat_count <= '0;
            beat       <= 1'b0;
        end else begin
            beat <= 1'b0;
            if (play_enable) begin
                if (beat_count == BEAT_CW'(`MUSIC_BEAT_DIV - 1)) begin
                    beat_count <= '0;
                    beat       <= 1'b1;
                end else begin
                    beat_count <= beat_count + 1'b1;
                end
            end
        end
    end

    assign end_of_song = (note_cmd.duration == '0);

    always_comb begin
        next_state = state;
        case (state)
            S_WAIT:  if (play_enable && done_with_note) next_state = S_FETCH;
            S_FETCH: if (play_enable) next_state = S_READY;
            S_READY: if (play_enable) next_state = end_of_song ? S_END : S_WAIT;
            S_END:   next_state = S_END;
            default: next_state = S_WAIT;
        endcase
    end

    // Load happens two cycles after done_with_note rises
    assign load_new_note = play_enable && (state == S_READY) && !end_of_song;
    assign load_cmd      = note_cmd;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_WAIT;
            song_addr  <= '0;
            note_index <= '0;
            song_done  <= 1'b0;
        end else begin
            state <= next_state;
            if (load_new_note) begin
                note_index <= song_addr;           // Entry just loaded
                song_addr  <= song_addr + 1'b1;    // Ready for the next fetch
            end
            if (play_enable && (state == S_READY) && end_of_song) begin
                song_done <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/music_player.sv ====
`timescale 1ns/1ps
`include "music_settings.svh"

module music_player (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      play_enable,           // Level from the codec side
    input  logic                      generate_next_sample,  // Sample request strobe
    output music_pkg::sample_t        sample_out,            // Mixed audio sample
    output logic                      new_sample_ready,      // Sample valid strobe
    output logic [`MUSIC_SONG_AW-1:0] note_index,            // Song entry now sounding
    output logic                      song_done              // End of song reached
);

    logic [`MUSIC_SONG_AW-1:0] song_addr;
    music_pkg::note_cmd_t      rom_cmd;         // ROM word back to the sequencer
    music_pkg::note_cmd_t      load_cmd;        // Note handed to the player
    logic                      load_new_note;
    logic                      beat;
    logic                      done_with_note;

    song_sequencer sequencer (
        .clk(clk), .reset(reset), .play_enable(play_enable),
        .note_cmd(rom_cmd), .done_with_note(done_with_note),
        .song_addr(song_addr), .load_new_note(load_new_note), .load_cmd(load_cmd),
        .beat(beat), .note_index(note_index), .song_done(song_done)
    );

    song_rom rom (.clk(clk), .song_addr(song_addr), .note_cmd(rom_cmd));

    note_player player (
        .clk(clk), .reset(reset), .play_enable(play_enable),
        .load_new_note(load_new_note), .note_cmd(load_cmd), .beat(beat),
        .generate_next_sample(generate_next_sample),
        .done_with_note(done_with_note), .sample_out(sample_out),
        .new_sample_ready(new_sample_ready)
    );

endmodule

// ==== testbench/music_player_sva.sv ====
`timescale 1ns/1ps

module music_player_sva (
    input logic               clk,
    input logic               reset,
    input logic               play_enable,
    input logic               generate_next_sample,
    input logic               new_sample_ready,
    input music_pkg::sample_t sample_out
);

    logic request;  // Request that the player accepts

    assign request = play_enable && generate_next_sample;

    // Each accepted request gives a pulse three cycles on
    request_to_ready: assert property (@(posedge clk) disable iff (reset)
        request |-> ##3 new_sample_ready)
        else $error("ready pulse missing three cycles after a request");

    // No pulse without a matching request
    ready_has_request: assert property (@(posedge clk) disable iff (reset)
        new_sample_ready |-> $past(request, 3))
        else $error("ready pulse without a request three cycles earlier");

    // Outputs held quiet once reset has taken effect
    quiet_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> (!new_sample_ready && sample_out == '0))
        else $error("strobe or sample active during reset");

endmodule

bind note_player music_player_sva sva_i (
    .clk                 (clk),
    .reset               (reset),
    .play_enable         (play_enable),
    .generate_next_sample(generate_next_sample),
    .new_sample_ready    (new_sample_ready),
    .sample_out          (sample_out)
);

// ==== testbench/music_player_tb.sv ====
`timescale 1ns/1ps
`include "music_settings.svh"

module music_player_tb;

    localparam int NUM_ROWS = 11;
    localparam int NUM_SONG = 13;
    localparam int MARGIN   = 3;  // Allowed slack on note timing, in cycles
    localparam int SETTLE   = 8;  // Pipeline flush after a note change

    typedef struct {
        string name;
        bit    play;       // play_enable level for the row
        int    mode;       // 0 no requests, 1 back to back, 2 random gaps
        int    cycles;
        int    exp_index;
        bit    exp_done;
        bit    silent;     // Every sample in the row must be 0
    } row_t;

    logic               clk;
    logic               reset;
    logic               play_enable;
    logic               generate_next_sample;
    music_pkg::sample_t sample_out;
    logic               new_sample_ready;
    logic [`MUSIC_SONG_AW-1:0] note_index;
    logic               song_done;

    row_t        rows [NUM_ROWS];
    int          song_note [NUM_SONG] = '{25, 27, 29, 30, 0, 32, 34, 37, 36, 0, 49, 44, 0};
    int          song_dur  [NUM_SONG] = '{2, 2, 1, 3, 2, 2, 1, 4, 2, 1, 2, 3, 0};
    logic [31:0] lfsr = 32'ha312;
    logic [2:0]  req_hist = '0;  // Accepted requests of the last three cycles
    int          checks = 0;
    int          errors = 0;
    int          pulses;
    int          requests;
    int          entry_cycles = 0;    // Play cycles spent on the current entry
    bit          entry_skip = 1'b1;   // Start of entry 0 unseen, pauses drop beats
    int          since_change = 0;
    int          last_index = 0;
    bit          done_seen = 1'b0;

    music_player dut_i (
        .clk(clk), .reset(reset), .play_enable(play_enable),
        .generate_next_sample(generate_next_sample),
        .sample_out(sample_out), .new_sample_ready(new_sample_ready),
        .note_index(note_index), .song_done(song_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic compare(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // Entry timing against the song copy, within the margin
    task automatic check_entry_time(input int entry);
        int exp_cycles;
        exp_cycles = song_dur[entry] * `MUSIC_BEAT_DIV;
        if (!entry_skip) begin
            compare($sformatf("entry_%0d_cycles", entry), exp_cycles,
                    (entry_cycles >= exp_cycles - MARGIN && entry_cycles <= exp_cycles + MARGIN)
                    ? exp_cycles : entry_cycles);
        end
        entry_cycles = 0;
        entry_skip   = 1'b0;
        since_change = 0;
    endtask

    // Runs at each falling edge, where outputs are stable
    task automatic watch_outputs(input row_t row);
        compare({row.name, "_ready_timing"}, req_hist[2], new_sample_ready);
        req_hist = {req_hist[1:0], play_enable && generate_next_sample};
        if (play_enable) begin
            entry_cycles++;
        end else begin
            entry_skip = 1'b1;
        end
        since_change++;
        if (new_sample_ready) begin
            pulses++;
            if (row.silent) compare({row.name, "_silence"}, 0, int'(sample_out));
            if (song_note[note_index] == 0 && since_change > SETTLE) begin
                compare({row.name, "_rest_sample"}, 0, int'(sample_out));
            end
        end
        if (int'(note_index) != last_index) begin
            if (!play_enable || done_seen) begin
                $display("note_index changed while paused or after the song ended");
                errors++;
            end
            compare({row.name, "_index_step"}, last_index + 1, int'(note_index));
            check_entry_time(last_index);
            last_index = int'(note_index);
        end
        if (song_done && !done_seen) begin
            done_seen = 1'b1;
            check_entry_time(last_index);  // Last note ends as the end entry is read
        end
    endtask

    initial begin
        rows[0]  = '{"reset_idle",     1'b0, 2, 20,  0,  1'b0, 1'b1};
        rows[1]  = '{"start_b2b",      1'b1, 1, 25,  0,  1'b0, 1'b0};
        rows[2]  = '{"pause_long",     1'b0, 2, 60,  0,  1'b0, 1'b1};
        rows[3]  = '{"play_to_rest",   1'b1, 2, 115, 4,  1'b0, 1'b0};
        rows[4]  = '{"rest_silence",   1'b1, 1, 18,  4,  1'b0, 1'b1};
        rows[5]  = '{"play_random",    1'b1, 2, 67,  7,  1'b0, 1'b0};
        rows[6]  = '{"pause_short",    1'b0, 0, 30,  7,  1'b0, 1'b1};
        rows[7]  = '{"resume_b2b",     1'b1, 1, 60,  8,  1'b0, 1'b0};
        rows[8]  = '{"second_rest",    1'b1, 2, 50,  10, 1'b0, 1'b0};
        rows[9]  = '{"to_end",         1'b1, 2, 120, 11, 1'b1, 1'b0};
        rows[10] = '{"after_end",      1'b1, 1, 40,  11, 1'b1, 1'b0};
    end

    initial begin
        int limit;
        #1;
        limit = 100;
        foreach (rows[i]) limit += rows[i].cycles;
        #(limit * 40);
        $display("Watchdog: the run timed out before all tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        bit req;
        reset                = 1'b1;
        play_enable          = 1'b0;
        generate_next_sample = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare("reset_ready", 0, new_sample_ready);
        compare("reset_sample", 0, int'(sample_out));
        compare("reset_index", 0, int'(note_index));
        compare("reset_done", 0, song_done);
        @(posedge clk);
        #2 reset = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            pulses   = 0;
            requests = 0;
            for (int c = 0; c < rows[r].cycles; c++) begin
                @(posedge clk);
                #2;
                req = 1'b0;
                if (rows[r].mode == 1) begin
                    req = 1'b1;
                end else if (rows[r].mode == 2) begin
                    lfsr = lfsr_next(lfsr);
                    req  = lfsr[0];
                end
                if (c >= rows[r].cycles - 3) req = 1'b0;  // Let the pipeline drain
                play_enable          = rows[r].play;
                generate_next_sample = req;
                if (rows[r].play && req) requests++;
                @(negedge clk);
                watch_outputs(rows[r]);
            end
            compare({rows[r].name, "_strobes"}, requests, pulses);
            compare({rows[r].name, "_index"}, rows[r].exp_index, int'(note_index));
            compare({rows[r].name, "_done"}, rows[r].exp_done, song_done);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/music_pkg.sv
rtl/song_rom.sv
rtl/frequency_rom.sv
rtl/sine_rom.sv
rtl/sine_reader.sv
rtl/note_player.sv
rtl/song_sequencer.sv
rtl/music_player.sv
testbench/music_player_sva.sv
testbench/music_player_tb.sv

// ==== Bender.yml ====
package:
  name: music_player

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/music_pkg.sv
      - rtl/song_rom.sv
      - rtl/frequency_rom.sv
      - rtl/sine_rom.sv
      - rtl/sine_reader.sv
      - rtl/note_player.sv
      - rtl/song_sequencer.sv
      - rtl/music_player.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/music_player_sva.sv
      - testbench/music_player_tb.sv
